/* src.f */
+incdir+common
common/axi_pkg.sv
common/soc_pkg.sv
common/axi_lite_if.sv
arbiter/bus_arbiter.sv
source/clint.sv
source/sram_slave.sv
source/mem_subsystem.sv
sim/tb_mem_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_mem_subsystem -o tb_mem_subsystem

# The model exits nonzero on $fatal, so the log decides the result.
./obj_dir/tb_mem_subsystem > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log || ! grep -q "Finished with no errors" sim.log; then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi

echo "Simulation passed"

/* sim/tb_mem_subsystem.sv */
`timescale 1ns/10ps
`include "soc_defines.svh"

module tb_mem_subsystem;
  import axi_pkg::*;

  typedef enum {OP_READ, OP_WRITE, OP_DUAL, OP_MTIME} op_t;

  typedef struct {
    string name;
    bit    is_lsu;
    op_t   op;
    addr_t addr;
    data_t wdata;  // Dual reads keep lsu's expected word here, read at addr + 4.
    strb_t strb;
    data_t exp;
    resp_t resp;
  } test_t;

  localparam addr_t RAM = `RAM_BASE;
  localparam addr_t HOLE = 32'h1000_0000;  // Nothing mapped here.

  logic  clock;
  logic  rst_n;
  addr_t ifu_araddr;
  logic  ifu_arvalid;
  logic  ifu_arready;
  data_t ifu_rdata;
  resp_t ifu_rresp;
  logic  ifu_rvalid;
  logic  ifu_rready;
  addr_t lsu_araddr;
  logic  lsu_arvalid;
  logic  lsu_arready;
  data_t lsu_rdata;
  resp_t lsu_rresp;
  logic  lsu_rvalid;
  logic  lsu_rready;
  addr_t lsu_awaddr;
  logic  lsu_awvalid;
  logic  lsu_awready;
  data_t lsu_wdata;
  strb_t lsu_wstrb;
  logic  lsu_wvalid;
  logic  lsu_wready;
  resp_t lsu_bresp;
  logic  lsu_bvalid;
  logic  lsu_bready;

  test_t       tests[$];
  int unsigned seed = 95;
  int          cycles;
  int          limit;
  data_t       last_mtime;
  bit          have_mtime;

  mem_subsystem UUT (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic int unsigned next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed >> 16;
  endfunction

  task automatic add_test(input string name, input bit is_lsu, input op_t op, input addr_t addr,
                          input data_t wdata, input strb_t strb, input data_t exp,
                          input resp_t resp);
    test_t t;
    t = '{name, is_lsu, op, addr, wdata, strb, exp, resp};
    tests.push_back(t);
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      $display("Finished with errors");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  function automatic logic cur_valid(input bit is_lsu, input bit is_wr);
    if (is_wr)
      return lsu_bvalid;
    return is_lsu ? lsu_rvalid : ifu_rvalid;
  endfunction

  function automatic data_t cur_data(input bit is_lsu, input bit is_wr);
    if (is_wr)
      return '0;
    return is_lsu ? lsu_rdata : ifu_rdata;
  endfunction

  function automatic resp_t cur_resp(input bit is_lsu, input bit is_wr);
    if (is_wr)
      return lsu_bresp;
    return is_lsu ? lsu_rresp : ifu_rresp;
  endfunction

  task automatic set_ready(input bit is_lsu, input bit is_wr, input logic val);
    if (is_wr)
      lsu_bready <= val;
    else if (is_lsu)
      lsu_rready <= val;
    else
      ifu_rready <= val;
  endtask

  // Waits for r or b, stalls ready for 0 to 3 cycles, then completes the handshake.
  task automatic wait_response(input string name, input bit is_lsu, input bit is_wr,
                               output data_t data, output resp_t resp);
    int   delay;
    logic valid;
    delay = next_rand() % 4;
    valid = 1'b0;
    while (!valid) begin
      @(posedge clock);
      valid = cur_valid(is_lsu, is_wr);
    end
    data = cur_data(is_lsu, is_wr);
    resp = cur_resp(is_lsu, is_wr);
    repeat (delay) begin
      @(posedge clock);
      compare({name, " valid held"}, 32'd1, 32'(cur_valid(is_lsu, is_wr)));
      compare({name, " resp held"}, 32'(resp), 32'(cur_resp(is_lsu, is_wr)));
      if (!is_wr)
        compare({name, " data held"}, data, cur_data(is_lsu, is_wr));
    end
    set_ready(is_lsu, is_wr, 1'b1);
    @(posedge clock);
    compare({name, " handshake"}, 32'd1, 32'(cur_valid(is_lsu, is_wr)));
    compare({name, " resp at handshake"}, 32'(resp), 32'(cur_resp(is_lsu, is_wr)));
    if (!is_wr)
      compare({name, " data at handshake"}, data, cur_data(is_lsu, is_wr));
    set_ready(is_lsu, is_wr, 1'b0);
  endtask

  task automatic do_read(input string name, input bit is_lsu, input addr_t addr,
                         output data_t data, output resp_t resp);
    logic ready;
    @(posedge clock);
    if (is_lsu) begin
      lsu_araddr  <= addr;
      lsu_arvalid <= 1'b1;
    end else begin
      ifu_araddr  <= addr;
      ifu_arvalid <= 1'b1;
    end
    ready = 1'b0;
    while (!ready) begin
      @(posedge clock);
      ready = is_lsu ? lsu_arready : ifu_arready;
    end
    if (is_lsu)
      lsu_arvalid <= 1'b0;
    else
      ifu_arvalid <= 1'b0;
    wait_response(name, is_lsu, 1'b0, data, resp);
  endtask

  task automatic do_write(input string name, input addr_t addr, input data_t wdata,
                          input strb_t strb, output resp_t resp);
    data_t unused;
    logic  ready;
    @(posedge clock);
    lsu_awaddr  <= addr;
    lsu_awvalid <= 1'b1;
    lsu_wdata   <= wdata;
    lsu_wstrb   <= strb;
    lsu_wvalid  <= 1'b1;
    ready = 1'b0;
    while (!ready) begin
      @(posedge clock);
      ready = lsu_awready & lsu_wready;  // aw and w go in one handshake.
    end
    lsu_awvalid <= 1'b0;
    lsu_wvalid  <= 1'b0;
    wait_response(name, 1'b1, 1'b1, unused, resp);
  endtask

  initial begin
    test_t t;
    data_t data;
    data_t data2;
    resp_t resp;
    resp_t resp2;
    rst_n       <= 1'b0;
    ifu_araddr  <= '0;
    ifu_arvalid <= 1'b0;
    ifu_rready  <= 1'b0;
    lsu_araddr  <= '0;
    lsu_arvalid <= 1'b0;
    lsu_rready  <= 1'b0;
    lsu_awaddr  <= '0;
    lsu_awvalid <= 1'b0;
    lsu_wdata   <= '0;
    lsu_wstrb   <= '0;
    lsu_wvalid  <= 1'b0;
    lsu_bready  <= 1'b0;
    have_mtime  = 1'b0;

    add_test("wr_full", 1'b1, OP_WRITE, RAM + 'h10, 32'h1122_3344, 4'hf, '0, RESP_OKAY);
    add_test("wr_part", 1'b1, OP_WRITE, RAM + 'h10, 32'haabb_ccdd, 4'h5, '0, RESP_OKAY);
    add_test("rd_merged", 1'b1, OP_READ, RAM + 'h10, '0, '0, 32'h11bb_33dd, RESP_OKAY);
    add_test("wr_top", 1'b1, OP_WRITE, RAM + 'h10, 32'h7700_0000, 4'h8, '0, RESP_OKAY);
    add_test("ifu_rd_lsu", 1'b0, OP_READ, RAM + 'h10, '0, '0, 32'h77bb_33dd, RESP_OKAY);
    add_test("wr_a", 1'b1, OP_WRITE, RAM + 'h20, 32'hcafe_f00d, 4'hf, '0, RESP_OKAY);
    add_test("wr_b", 1'b1, OP_WRITE, RAM + 'h24, 32'h0bad_beef, 4'hf, '0, RESP_OKAY);
    add_test("dual_rd", 1'b0, OP_DUAL, RAM + 'h20, 32'h0bad_beef, '0, 32'hcafe_f00d, RESP_OKAY);
    add_test("mtime_hi", 1'b0, OP_READ, `CLINT_MTIME_HI, '0, '0, '0, RESP_OKAY);
    add_test("mtime_lo_a", 1'b1, OP_MTIME, `CLINT_MTIME_LO, '0, '0, '0, RESP_OKAY);
    add_test("mtime_lo_b", 1'b0, OP_MTIME, `CLINT_MTIME_LO, '0, '0, '0, RESP_OKAY);
    add_test("hole_rd", 1'b1, OP_READ, HOLE, '0, '0, '0, RESP_DECERR);
    add_test("hole_wr", 1'b1, OP_WRITE, HOLE, 32'h1234_5678, 4'hf, '0, RESP_DECERR);

    repeat (5) @(posedge clock);
    rst_n <= 1'b1;

    foreach (tests[i]) begin
      t = tests[i];
      case (t.op)
        OP_WRITE: begin
          do_write(t.name, t.addr, t.wdata, t.strb, resp);
          compare({t.name, " bresp"}, 32'(t.resp), 32'(resp));
        end
        OP_DUAL: begin
          fork
            do_read({t.name, " ifu"}, 1'b0, t.addr, data, resp);
            do_read({t.name, " lsu"}, 1'b1, t.addr + 4, data2, resp2);
          join
          compare({t.name, " ifu data"}, t.exp, data);
          compare({t.name, " ifu rresp"}, 32'(t.resp), 32'(resp));
          compare({t.name, " lsu data"}, t.wdata, data2);
          compare({t.name, " lsu rresp"}, 32'(t.resp), 32'(resp2));
        end
        default: begin
          do_read(t.name, t.is_lsu, t.addr, data, resp);
          compare({t.name, " rresp"}, 32'(t.resp), 32'(resp));
          if (t.op == OP_READ) begin
            compare({t.name, " data"}, t.exp, data);
          end else begin
            compare({t.name, " nonzero"}, 32'd1, 32'(data != '0));
            if (have_mtime)
              compare({t.name, " increasing"}, 32'd1, 32'(data > last_mtime));
            last_mtime = data;
            have_mtime = 1'b1;
          end
        end
      endcase
    end

    repeat (2) @(posedge clock);
    $display("Finished with no errors");
    $finish;
  end

  // Roughly 20 cycles per entry covers grant wait plus the longest stall.
  initial begin
    cycles = 0;
    @(posedge rst_n);
    limit = tests.size() * 20 + 100;
    while (cycles < limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles.", limit);
    $display("Finished with errors");
    $fatal(1, "Run stopped by the cycle limit.");
  end

endmodule

/* source/mem_subsystem.sv */
`timescale 1ns/10ps

module mem_subsystem (
  input  logic            clock,
  input  logic            rst_n,

  input  axi_pkg::addr_t  ifu_araddr,
  input  logic            ifu_arvalid,
  output logic            ifu_arready,
  output axi_pkg::data_t  ifu_rdata,
  output axi_pkg::resp_t  ifu_rresp,
  output logic            ifu_rvalid,
  input  logic            ifu_rready,

  input  axi_pkg::addr_t  lsu_araddr,
  input  logic            lsu_arvalid,
  output logic            lsu_arready,
  output axi_pkg::data_t  lsu_rdata,
  output axi_pkg::resp_t  lsu_rresp,
  output logic            lsu_rvalid,
  input  logic            lsu_rready,

  input  axi_pkg::addr_t  lsu_awaddr,
  input  logic            lsu_awvalid,
  output logic            lsu_awready,
  input  axi_pkg::data_t  lsu_wdata,
  input  axi_pkg::strb_t  lsu_wstrb,
  input  logic            lsu_wvalid,
  output logic            lsu_wready,
  output axi_pkg::resp_t  lsu_bresp,
  output logic            lsu_bvalid,
  input  logic            lsu_bready
);

  axi_lite_if ifu_bus ();
  axi_lite_if lsu_bus ();
  axi_lite_if ram_bus ();
  axi_lite_if clint_bus ();

  assign ifu_bus.araddr = ifu_araddr;
  assign ifu_bus.arvalid = ifu_arvalid;
  assign ifu_bus.rready = ifu_rready;
  assign ifu_arready = ifu_bus.arready;
  assign ifu_rdata = ifu_bus.rdata;
  assign ifu_rresp = ifu_bus.rresp;
  assign ifu_rvalid = ifu_bus.rvalid;

  // Fetch never writes.
  assign ifu_bus.awaddr = '0;
  assign ifu_bus.awvalid = 1'b0;
  assign ifu_bus.wdata = '0;
  assign ifu_bus.wstrb = '0;
  assign ifu_bus.wvalid = 1'b0;
  assign ifu_bus.bready = 1'b0;

  assign lsu_bus.araddr = lsu_araddr;
  assign lsu_bus.arvalid = lsu_arvalid;
  assign lsu_bus.rready = lsu_rready;
  assign lsu_bus.awaddr = lsu_awaddr;
  assign lsu_bus.awvalid = lsu_awvalid;
  assign lsu_bus.wdata = lsu_wdata;
  assign lsu_bus.wstrb = lsu_wstrb;
  assign lsu_bus.wvalid = lsu_wvalid;
  assign lsu_bus.bready = lsu_bready;
  assign lsu_arready = lsu_bus.arready;
  assign lsu_rdata = lsu_bus.rdata;
  assign lsu_rresp = lsu_bus.rresp;
  assign lsu_rvalid = lsu_bus.rvalid;
  assign lsu_awready = lsu_bus.awready;
  assign lsu_wready = lsu_bus.wready;
  assign lsu_bresp = lsu_bus.bresp;
  assign lsu_bvalid = lsu_bus.bvalid;

  bus_arbiter u_arbiter (
    .clock (clock),
    .rst_n (rst_n),
    .ifu   (ifu_bus.slv),
    .lsu   (lsu_bus.slv),
    .ram   (ram_bus.mst),
    .clt   (clint_bus.mst)
  );

  sram_slave u_sram (
    .clock (clock),
    .rst_n (rst_n),
    .bus   (ram_bus.slv)
  );

  clint u_clint (
    .clock (clock),
    .rst_n (rst_n),
    .bus   (clint_bus.slv)
  );

endmodule

/* source/sram_slave.sv */
`timescale 1ns/10ps
`include "soc_defines.svh"

module sram_slave (
  input  logic    clock,
  input  logic    rst_n,
  axi_lite_if.slv bus
);
  import axi_pkg::*;

  localparam int IDX_W = $clog2(`RAM_WORDS);

  data_t            mem [`RAM_WORDS];
  addr_t            rd_off;
  addr_t            wr_off;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;
  logic             busy;
  logic             rd_hs;
  logic             wr_hs;

  // Word offset from the RAM base.
  assign rd_off = bus.araddr - `RAM_BASE;
  assign wr_off = bus.awaddr - `RAM_BASE;
  assign rd_idx = rd_off[IDX_W+1:2];
  assign wr_idx = wr_off[IDX_W+1:2];

  assign busy        = bus.rvalid | bus.bvalid;
  assign bus.arready = !busy;
  assign bus.awready = !busy && !bus.arvalid;
  assign bus.wready  = bus.awready;  // aw and w are taken together.
  assign bus.rresp   = RESP_OKAY;
  assign bus.bresp   = RESP_OKAY;

  assign rd_hs = bus.arvalid & bus.arready;
  assign wr_hs = bus.awvalid & bus.wvalid & bus.awready;

  always_ff @(posedge clock) begin
    if (wr_hs) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.wstrb[i])
          mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
      end
    end
    if (rd_hs)
      bus.rdata <= mem[rd_idx];  // Held until the next read.
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      bus.rvalid <= 1'b0;
      bus.bvalid <= 1'b0;
    end else begin
      if (rd_hs)
        bus.rvalid <= 1'b1;
      else if (bus.rready)
        bus.rvalid <= 1'b0;
      if (wr_hs)
        bus.bvalid <= 1'b1;
      else if (bus.bready)
        bus.bvalid <= 1'b0;
    end
  end

  // Out-of-window requests would alias onto low words.
  a_rd_in_ram: assert property (@(posedge clock) disable iff (!rst_n)
    rd_hs |-> rd_off < 4 * `RAM_WORDS);

  a_wr_in_ram: assert property (@(posedge clock) disable iff (!rst_n)
    wr_hs |-> wr_off < 4 * `RAM_WORDS);

endmodule

/* source/clint.sv */
`timescale 1ns/10ps

module clint (
  input  logic    clock,
  input  logic    rst_n,
  axi_lite_if.slv bus
);
  import axi_pkg::*;

  logic [63:0] mtime;
  logic        busy;
  logic        rd_hs;
  logic        wr_hs;

  assign busy        = bus.rvalid | bus.bvalid;
  assign bus.arready = !busy;
  assign bus.awready = !busy && !bus.arvalid;  // Reads first.
  assign bus.wready  = bus.awready;
  assign bus.rresp   = RESP_OKAY;
  assign bus.bresp   = RESP_OKAY;

  assign rd_hs = bus.arvalid & bus.arready;
  assign wr_hs = bus.awvalid & bus.wvalid & bus.awready;

  always_ff @(posedge clock) begin
    if (!rst_n)
      mtime <= '0;
    else
      mtime <= mtime + 64'd1;
  end

  // Address bit 2 picks the high word.
  always_ff @(posedge clock) begin
    if (rd_hs)
      bus.rdata <= bus.araddr[2] ? mtime[63:32] : mtime[31:0];
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      bus.rvalid <= 1'b0;
      bus.bvalid <= 1'b0;
    end else begin
      if (rd_hs)
        bus.rvalid <= 1'b1;
      else if (bus.rready)
        bus.rvalid <= 1'b0;
      if (wr_hs)
        bus.bvalid <= 1'b1;  // Write data is dropped.
      else if (bus.bready)
        bus.bvalid <= 1'b0;
    end
  end

endmodule

/* arbiter/bus_arbiter.sv */
`timescale 1ns/10ps
`include "soc_defines.svh"

module bus_arbiter (
  input  logic    clock,
  input  logic    rst_n,
  axi_lite_if.slv ifu,
  axi_lite_if.slv lsu,
  axi_lite_if.mst ram,
  axi_lite_if.mst clt
);
  import axi_pkg::*;
  import soc_pkg::*;

  arb_state_t state;
  master_t    gnt;
  master_t    last_gnt;
  master_t    pick_mst;
  target_t    tgt;
  target_t    pick_tgt;
  logic       addr_done;  // Request already taken by the target.
  logic       lsu_wr_req;
  logic       lsu_req;
  logic       pick_wr;
  addr_t      pick_addr;

  addr_t m_araddr;
  addr_t m_awaddr;
  data_t m_wdata;
  strb_t m_wstrb;
  logic  m_arvalid;
  logic  m_awvalid;
  logic  m_wvalid;
  logic  m_rready;
  logic  m_bready;
  logic  m_arready;
  logic  m_awready;
  logic  is_ifu;
  logic  is_clt;
  logic  fwd_ar;
  logic  fwd_aw;
  logic  r_valid;
  logic  b_valid;
  data_t r_data;
  resp_t r_resp;
  resp_t b_resp;

  function automatic target_t decode(input addr_t addr);
    if (addr >= `RAM_BASE && addr < `RAM_BASE + 4 * `RAM_WORDS)
      return TGT_RAM;
    else if (addr == `CLINT_MTIME_LO || addr == `CLINT_MTIME_HI)
      return TGT_CLINT;
    else
      return TGT_NONE;
  endfunction

  // Only complete writes count as requests. Writes beat reads on lsu.
  assign lsu_wr_req = lsu.awvalid & lsu.wvalid;
  assign lsu_req    = lsu_wr_req | lsu.arvalid;
  assign pick_mst   = (ifu.arvalid && lsu_req) ? (last_gnt == MST_IFU ? MST_LSU : MST_IFU)
                    : (ifu.arvalid ? MST_IFU : MST_LSU);
  assign pick_wr    = (pick_mst == MST_LSU) && lsu_wr_req;
  assign pick_addr  = (pick_mst == MST_IFU) ? ifu.araddr : (pick_wr ? lsu.awaddr : lsu.araddr);
  assign pick_tgt   = decode(pick_addr);

  // Granted master's request side.
  assign is_ifu    = (gnt == MST_IFU);
  assign m_araddr  = is_ifu ? ifu.araddr : lsu.araddr;
  assign m_arvalid = is_ifu ? ifu.arvalid : lsu.arvalid;
  assign m_rready  = is_ifu ? ifu.rready : lsu.rready;
  assign m_awaddr  = is_ifu ? ifu.awaddr : lsu.awaddr;
  assign m_awvalid = is_ifu ? ifu.awvalid : lsu.awvalid;
  assign m_wdata   = is_ifu ? ifu.wdata : lsu.wdata;
  assign m_wstrb   = is_ifu ? ifu.wstrb : lsu.wstrb;
  assign m_wvalid  = is_ifu ? ifu.wvalid : lsu.wvalid;
  assign m_bready  = is_ifu ? ifu.bready : lsu.bready;

  assign is_clt = (tgt == TGT_CLINT);
  assign fwd_ar = (state == ARB_RD) && !addr_done && m_arvalid;
  assign fwd_aw = (state == ARB_WR) && !addr_done && m_awvalid && m_wvalid;

  assign m_arready = (fwd_ar && (is_clt ? clt.arready : ram.arready))
                   || (state == ARB_ERR_R && !addr_done);
  assign m_awready = (fwd_aw && (is_clt ? clt.awready & clt.wready : ram.awready & ram.wready))
                   || (state == ARB_ERR_B && !addr_done);

  // Responses pass straight through; error states answer locally.
  assign r_valid = (state == ARB_ERR_R) || (state == ARB_RD && (is_clt ? clt.rvalid : ram.rvalid));
  assign r_data  = (state == ARB_ERR_R) ? '0 : (is_clt ? clt.rdata : ram.rdata);
  assign r_resp  = (state == ARB_ERR_R) ? RESP_DECERR : (is_clt ? clt.rresp : ram.rresp);
  assign b_valid = (state == ARB_ERR_B) || (state == ARB_WR && (is_clt ? clt.bvalid : ram.bvalid));
  assign b_resp  = (state == ARB_ERR_B) ? RESP_DECERR : (is_clt ? clt.bresp : ram.bresp);

  assign ifu.arready = is_ifu & m_arready;
  assign ifu.rdata   = r_data;
  assign ifu.rresp   = r_resp;
  assign ifu.rvalid  = is_ifu & r_valid;
  assign ifu.awready = is_ifu & m_awready;
  assign ifu.wready  = is_ifu & m_awready;
  assign ifu.bresp   = b_resp;
  assign ifu.bvalid  = is_ifu & b_valid;

  assign lsu.arready = !is_ifu & m_arready;
  assign lsu.rdata   = r_data;
  assign lsu.rresp   = r_resp;
  assign lsu.rvalid  = !is_ifu & r_valid;
  assign lsu.awready = !is_ifu & m_awready;
  assign lsu.wready  = !is_ifu & m_awready;
  assign lsu.bresp   = b_resp;
  assign lsu.bvalid  = !is_ifu & b_valid;

  assign ram.araddr  = m_araddr;
  assign ram.arvalid = fwd_ar && (tgt == TGT_RAM);
  assign ram.rready  = (state == ARB_RD) && (tgt == TGT_RAM) && m_rready;
  assign ram.awaddr  = m_awaddr;
  assign ram.awvalid = fwd_aw && (tgt == TGT_RAM);
  assign ram.wdata   = m_wdata;
  assign ram.wstrb   = m_wstrb;
  assign ram.wvalid  = fwd_aw && (tgt == TGT_RAM);
  assign ram.bready  = (state == ARB_WR) && (tgt == TGT_RAM) && m_bready;

  assign clt.araddr  = m_araddr;
  assign clt.arvalid = fwd_ar && is_clt;
  assign clt.rready  = (state == ARB_RD) && is_clt && m_rready;
  assign clt.awaddr  = m_awaddr;
  assign clt.awvalid = fwd_aw && is_clt;
  assign clt.wdata   = m_wdata;
  assign clt.wstrb   = m_wstrb;
  assign clt.wvalid  = fwd_aw && is_clt;
  assign clt.bready  = (state == ARB_WR) && is_clt && m_bready;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state     <= ARB_IDLE;
      gnt       <= MST_IFU;
      last_gnt  <= MST_LSU;  // First contended grant goes to ifu.
      tgt       <= TGT_NONE;
      addr_done <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (ifu.arvalid || lsu_req) begin
            gnt       <= pick_mst;
            tgt       <= pick_tgt;
            addr_done <= 1'b0;
            if (ifu.arvalid && lsu_req)
              last_gnt <= pick_mst;  // Pointer moves on contention only.
            if (pick_tgt == TGT_NONE)
              state <= pick_wr ? ARB_ERR_B : ARB_ERR_R;
            else
              state <= pick_wr ? ARB_WR : ARB_RD;
          end
        end
        ARB_RD, ARB_ERR_R: begin
          if (m_arready)
            addr_done <= 1'b1;
          if (r_valid && m_rready)
            state <= ARB_IDLE;
        end
        ARB_WR, ARB_ERR_B: begin
          if (m_awready)
            addr_done <= 1'b1;
          if (b_valid && m_bready)
            state <= ARB_IDLE;
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // One transaction in flight across both slaves.
  a_one_target: assert property (@(posedge clock) disable iff (!rst_n)
    $onehot0({ram.rvalid, ram.bvalid, clt.rvalid, clt.bvalid}));

  a_gnt_stable: assert property (@(posedge clock) disable iff (!rst_n)
    (r_valid && !m_rready) |=> $stable(gnt) && r_valid && $stable(r_data) && $stable(r_resp));

  a_b_stable: assert property (@(posedge clock) disable iff (!rst_n)
    (b_valid && !m_bready) |=> $stable(gnt) && b_valid && $stable(b_resp));

endmodule

/* common/axi_lite_if.sv */
`timescale 1ns/10ps

interface axi_lite_if;
  import axi_pkg::*;

  addr_t araddr;
  logic  arvalid;
  logic  arready;

  data_t rdata;
  resp_t rresp;
  logic  rvalid;
  logic  rready;

  addr_t awaddr;
  logic  awvalid;
  logic  awready;

  data_t wdata;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;

  resp_t bresp;
  logic  bvalid;
  logic  bready;

  modport mst (
    output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

  modport slv (
    input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

endinterface

/* common/soc_pkg.sv */
package soc_pkg;

  typedef enum logic [2:0] {
    ARB_IDLE,
    ARB_RD,
    ARB_WR,
    ARB_ERR_R,  // Arbiter answers the read itself.
    ARB_ERR_B
  } arb_state_t;

  typedef enum logic {
    MST_IFU,
    MST_LSU
  } master_t;

  typedef enum logic [1:0] {
    TGT_RAM,
    TGT_CLINT,
    TGT_NONE
  } target_t;

endpackage

/* common/axi_pkg.sv */
package axi_pkg;

  // One 32-bit word per beat, no bursts.
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;  // One bit per byte lane.
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_DECERR = 2'd3;  // Unmapped address.

endpackage

/* common/soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// On-chip RAM window.
`define RAM_BASE 32'h8000_0000
`define RAM_WORDS 1024

// mtime as two 32-bit words.
`define CLINT_MTIME_LO 32'h0200_0048
`define CLINT_MTIME_HI 32'h0200_004c

`endif
